/* hdl/island_bus_pkg.sv */
package island_bus_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  // ----------------------------------------
  // Bus word types
  // ----------------------------------------
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;

endpackage

/* hdl/island_map_pkg.sv */
package island_map_pkg;

  // ----------------------------------------
  // Address map
  // ----------------------------------------

  // Region code is address bits 31:12 with one 4 KiB window each
  typedef enum logic [19:0] {
    BankRegion = 20'h00000,
    RomRegion  = 20'h00001,
    CtrlRegion = 20'h00002
  } region_e;

  // Front end splits by region while targets index words
  typedef union packed {
    struct packed {
      region_e     region;
      logic [11:0] offset;
    } map;
    struct packed {
      logic [29:0] word_idx;
      logic [1:0]  byte_sel;
    } mem;
  } island_addr_u;

  // ----------------------------------------
  // Boot and fixed replies
  // ----------------------------------------
  typedef enum logic [1:0] {
    BootLocal  = 2'd0,
    BootJtag   = 2'd1,
    BootSerial = 2'd2
  } bootmode_e;

  localparam int unsigned RomWords = 64;
  localparam logic [15:0] RomTag   = 16'hB007;

  // ROM base
  localparam island_bus_pkg::addr_t BootAddrReset = 32'h0000_1000;
  localparam island_bus_pkg::data_t ErrorWord     = 32'hBADC_AB1E;

  // Control register offsets within CtrlRegion
  localparam logic [11:0] FetchEnOffset  = 12'h000;
  localparam logic [11:0] BootAddrOffset = 12'h004;
  localparam logic [11:0] StatusOffset   = 12'h008;

endpackage

/* hdl/periph_bus_if.sv */
`timescale 1ns/1ps

interface periph_bus_if;

  // Request lasts one cycle per transfer
  logic                         req;
  logic                         we;
  island_map_pkg::island_addr_u addr;
  island_bus_pkg::data_t        wdata;
  island_bus_pkg::strb_t        be;

  // Reply comes one cycle after req
  logic                         rvalid;
  island_bus_pkg::data_t        rdata;
  logic                         err;

  modport initiator (
    output req, we, addr, wdata, be,
    input  rvalid, rdata, err
  );

  modport target (
    input  req, we, addr, wdata, be,
    output rvalid, rdata, err
  );

endinterface

/* hdl/wb_frontend.sv */
`timescale 1ns/1ps

module wb_frontend (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  island_bus_pkg::addr_t wb_adr_i,
  input  island_bus_pkg::data_t wb_dat_i,
  input  island_bus_pkg::strb_t wb_sel_i,
  output island_bus_pkg::data_t wb_dat_o,
  output logic                  wb_ack_o,
  output logic                  wb_err_o,

  periph_bus_if.initiator       bank_o,
  periph_bus_if.initiator       rom_o,
  periph_bus_if.initiator       ctrl_o
);

  typedef enum logic {
    StIdle,
    StWait
  } state_e;

  typedef enum logic [1:0] {
    SelBank,
    SelRom,
    SelCtrl,
    SelErr
  } target_e;

  state_e                       state_q;
  target_e                      sel_d;
  target_e                      sel_q;
  logic                         start;
  logic                         req_q;
  logic                         err_valid_q;
  island_map_pkg::island_addr_u adr;

  logic                         rsp_valid;
  logic                         rsp_err;
  island_bus_pkg::data_t        rsp_data;

  // ----------------------------------------
  // Region decode
  // ----------------------------------------
  assign adr   = wb_adr_i;
  assign start = (state_q == StIdle) && wb_cyc_i && wb_stb_i;

  always_comb begin
    case (adr.map.region)
      island_map_pkg::BankRegion: sel_d = SelBank;
      island_map_pkg::RomRegion:  sel_d = SelRom;
      island_map_pkg::CtrlRegion: sel_d = SelCtrl;
      default:                    sel_d = SelErr;
    endcase
  end

  // ----------------------------------------
  // Transfer FSM
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= StIdle;
      sel_q       <= SelErr;
      req_q       <= 1'b0;
      err_valid_q <= 1'b0;
    end else begin
      req_q       <= start;
      // Internal error slave answers with the same latency as a target
      err_valid_q <= req_q && (sel_q == SelErr);
      if (start) begin
        sel_q <= sel_d;
      end
      case (state_q)
        StIdle: if (start) state_q <= StWait;
        StWait: if (rsp_valid) state_q <= StIdle;
        default: state_q <= StIdle;
      endcase
    end
  end

  // Master holds its fields until ack, so they go straight out
  assign bank_o.req   = req_q && (sel_q == SelBank);
  assign bank_o.we    = wb_we_i;
  assign bank_o.addr  = adr;
  assign bank_o.wdata = wb_dat_i;
  assign bank_o.be    = wb_sel_i;

  assign rom_o.req    = req_q && (sel_q == SelRom);
  assign rom_o.we     = wb_we_i;
  assign rom_o.addr   = adr;
  assign rom_o.wdata  = wb_dat_i;
  assign rom_o.be     = wb_sel_i;

  assign ctrl_o.req   = req_q && (sel_q == SelCtrl);
  assign ctrl_o.we    = wb_we_i;
  assign ctrl_o.addr  = adr;
  assign ctrl_o.wdata = wb_dat_i;
  assign ctrl_o.be    = wb_sel_i;

  // ----------------------------------------
  // Reply select
  // ----------------------------------------
  always_comb begin
    case (sel_q)
      SelBank: begin
        rsp_valid = bank_o.rvalid;
        rsp_data  = bank_o.rdata;
        rsp_err   = bank_o.err;
      end
      SelRom: begin
        rsp_valid = rom_o.rvalid;
        rsp_data  = rom_o.rdata;
        rsp_err   = rom_o.err;
      end
      SelCtrl: begin
        rsp_valid = ctrl_o.rvalid;
        rsp_data  = ctrl_o.rdata;
        rsp_err   = ctrl_o.err;
      end
      default: begin
        rsp_valid = err_valid_q;
        rsp_data  = island_map_pkg::ErrorWord;
        rsp_err   = 1'b1;
      end
    endcase
  end

  assign wb_dat_o = rsp_data;
  assign wb_ack_o = rsp_valid && !rsp_err && wb_cyc_i && wb_stb_i;
  assign wb_err_o = rsp_valid && rsp_err && wb_cyc_i && wb_stb_i;

endmodule

/* hdl/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank #(
  parameter int unsigned BankNumWords = 1024
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  periph_bus_if.target bus_i
);

  localparam int unsigned IdxWidth = $clog2(BankNumWords);

  island_bus_pkg::data_t mem [BankNumWords];
  island_bus_pkg::data_t rdata_q;
  logic [IdxWidth-1:0]   idx;
  logic                  rvalid_q;

  // Word index wraps within the bank
  assign idx = IdxWidth'(bus_i.addr.mem.word_idx % BankNumWords);

  // ----------------------------------------
  // Storage
  // ----------------------------------------
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      if (bus_i.we) begin
        for (int b = 0; b < island_bus_pkg::StrbWidth; b++) begin
          if (bus_i.be[b]) begin
            mem[idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = 1'b0;

endmodule

/* hdl/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom (
  input  logic         clk_i,
  input  logic         rst_ni,
  periph_bus_if.target bus_i
);

  island_bus_pkg::data_t rdata_q;
  logic                  err_q;
  logic                  rvalid_q;
  logic [15:0]           rom_idx;

  assign rom_idx = 16'(bus_i.addr.mem.word_idx % island_map_pkg::RomWords);

  // Tag in the upper half, word index in the lower
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      err_q   <= bus_i.we;
      rdata_q <= bus_i.we ? island_map_pkg::ErrorWord : {island_map_pkg::RomTag, rom_idx};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = err_q;

endmodule

/* hdl/soc_ctrl_regs.sv */
`timescale 1ns/1ps

module soc_ctrl_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  periph_bus_if.target              bus_i,
  input  island_map_pkg::bootmode_e bootmode_i,
  output logic                      fetch_enable_o,
  output island_bus_pkg::addr_t     boot_addr_o
);

  logic                  fetch_en_q;
  island_bus_pkg::addr_t boot_addr_q;
  island_bus_pkg::data_t status;
  island_bus_pkg::data_t rd_data;
  logic                  acc_err;
  logic                  wr_ok;

  island_bus_pkg::data_t rdata_q;
  logic                  err_q;
  logic                  rvalid_q;

  // Effective fetch enable and boot mode
  assign status = {29'b0, bootmode_i, fetch_enable_o};

  // ----------------------------------------
  // Offset decode
  // ----------------------------------------
  always_comb begin
    rd_data = island_map_pkg::ErrorWord;
    acc_err = 1'b0;
    case (bus_i.addr.map.offset)
      island_map_pkg::FetchEnOffset:  rd_data = {31'b0, fetch_en_q};
      island_map_pkg::BootAddrOffset: rd_data = boot_addr_q;
      island_map_pkg::StatusOffset: begin
        rd_data = status;
        // Status is read-only
        acc_err = bus_i.we;
      end
      default: acc_err = 1'b1;
    endcase
    if (acc_err) begin
      rd_data = island_map_pkg::ErrorWord;
    end
  end

  assign wr_ok = bus_i.req && bus_i.we && !acc_err;

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q  <= 1'b0;
      boot_addr_q <= island_map_pkg::BootAddrReset;
      rvalid_q    <= 1'b0;
    end else begin
      rvalid_q <= bus_i.req;
      if (wr_ok && bus_i.addr.map.offset == island_map_pkg::FetchEnOffset && bus_i.be[0]) begin
        fetch_en_q <= bus_i.wdata[0];
      end
      if (wr_ok && bus_i.addr.map.offset == island_map_pkg::BootAddrOffset) begin
        for (int b = 0; b < island_bus_pkg::StrbWidth; b++) begin
          if (bus_i.be[b]) begin
            boot_addr_q[8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      rdata_q <= rd_data;
      err_q   <= acc_err;
    end
  end

  assign bus_i.rvalid = rvalid_q;
  assign bus_i.rdata  = rdata_q;
  assign bus_i.err    = err_q;

  // JTAG boot lets the debugger start the core
  assign fetch_enable_o = fetch_en_q || (bootmode_i == island_map_pkg::BootJtag);
  assign boot_addr_o    = boot_addr_q;

endmodule

/* hdl/island_top.sv */
`timescale 1ns/1ps

module island_top #(
  parameter int unsigned BankNumWords = 1024
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Wishbone classic target
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  island_bus_pkg::addr_t     wb_adr_i,
  input  island_bus_pkg::data_t     wb_dat_i,
  input  island_bus_pkg::strb_t     wb_sel_i,
  output island_bus_pkg::data_t     wb_dat_o,
  output logic                      wb_ack_o,
  output logic                      wb_err_o,

  input  island_map_pkg::bootmode_e bootmode_i,
  output logic                      fetch_enable_o,
  output island_bus_pkg::addr_t     boot_addr_o
);

  periph_bus_if bank_bus ();
  periph_bus_if rom_bus ();
  periph_bus_if ctrl_bus ();

  // ----------------------------------------
  // Front end
  // ----------------------------------------
  wb_frontend u_frontend (
    .clk_i    ( clk_i    ),
    .rst_ni   ( rst_ni   ),
    .wb_cyc_i ( wb_cyc_i ),
    .wb_stb_i ( wb_stb_i ),
    .wb_we_i  ( wb_we_i  ),
    .wb_adr_i ( wb_adr_i ),
    .wb_dat_i ( wb_dat_i ),
    .wb_sel_i ( wb_sel_i ),
    .wb_dat_o ( wb_dat_o ),
    .wb_ack_o ( wb_ack_o ),
    .wb_err_o ( wb_err_o ),
    .bank_o   ( bank_bus ),
    .rom_o    ( rom_bus  ),
    .ctrl_o   ( ctrl_bus )
  );

  // ----------------------------------------
  // Targets
  // ----------------------------------------
  sram_bank #(
    .BankNumWords ( BankNumWords )
  ) u_bank (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .bus_i  ( bank_bus )
  );

  boot_rom u_rom (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .bus_i  ( rom_bus )
  );

  soc_ctrl_regs u_ctrl (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .bus_i          ( ctrl_bus       ),
    .bootmode_i     ( bootmode_i     ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

endmodule

/* bench/island_assert.sv */
`timescale 1ns/1ps

module island_assert #(
  parameter int unsigned BankNumWords = 1024
) (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      wb_cyc_i,
  input logic                      wb_stb_i,
  input logic                      wb_we_i,
  input island_bus_pkg::addr_t     wb_adr_i,
  input island_bus_pkg::data_t     wb_dat_i,
  input island_bus_pkg::strb_t     wb_sel_i,
  input island_bus_pkg::data_t     wb_dat_o,
  input logic                      wb_ack_o,
  input logic                      wb_err_o,
  input island_map_pkg::bootmode_e bootmode_i,
  input logic                      fetch_enable_o,
  input island_bus_pkg::addr_t     boot_addr_o
);

  int unsigned fail_cnt = 0;

  logic                  busy_q;
  logic                  start;
  logic                  done;
  logic [1:0]            start_pipe_q;
  logic                  req_we_q;
  island_bus_pkg::addr_t req_adr_q;
  island_bus_pkg::data_t req_dat_q;
  island_bus_pkg::strb_t req_sel_q;
  int unsigned           bank_idx;

  // Reference state built from the bus traffic
  island_bus_pkg::data_t shadow [BankNumWords];
  island_bus_pkg::strb_t shadow_vld [BankNumWords];
  logic                  fen_q;
  island_bus_pkg::addr_t boot_addr_q;
  logic                  fen_eff;

  logic                  exp_err;
  island_bus_pkg::data_t exp_data;
  island_bus_pkg::data_t exp_mask;

  function automatic island_bus_pkg::data_t expand_bytes(input island_bus_pkg::strb_t sel);
    island_bus_pkg::data_t mask;
    for (int b = 0; b < island_bus_pkg::StrbWidth; b++) begin
      mask[8*b +: 8] = {8{sel[b]}};
    end
    return mask;
  endfunction

  assign start    = !busy_q && wb_cyc_i && wb_stb_i;
  assign done     = wb_ack_o || wb_err_o;
  assign bank_idx = req_adr_q[31:2] % BankNumWords;
  assign fen_eff  = fen_q || (bootmode_i == island_map_pkg::BootJtag);

  // ----------------------------------------
  // Expected reply
  // ----------------------------------------
  always_comb begin
    exp_err  = 1'b1;
    exp_data = island_map_pkg::ErrorWord;
    exp_mask = '1;
    if (req_adr_q[31:12] == island_map_pkg::BankRegion) begin
      exp_err  = 1'b0;
      exp_data = shadow[bank_idx];
      // Bytes never written hold no known value
      exp_mask = req_we_q ? '0 : expand_bytes(shadow_vld[bank_idx]);
    end else if (req_adr_q[31:12] == island_map_pkg::RomRegion) begin
      if (!req_we_q) begin
        exp_err  = 1'b0;
        exp_data = {island_map_pkg::RomTag, 16'(req_adr_q[31:2] % island_map_pkg::RomWords)};
      end
    end else if (req_adr_q[31:12] == island_map_pkg::CtrlRegion) begin
      case (req_adr_q[11:0])
        island_map_pkg::FetchEnOffset: begin
          exp_err  = 1'b0;
          exp_data = {31'b0, fen_q};
        end
        island_map_pkg::BootAddrOffset: begin
          exp_err  = 1'b0;
          exp_data = boot_addr_q;
        end
        island_map_pkg::StatusOffset: begin
          if (!req_we_q) begin
            exp_err  = 1'b0;
            exp_data = {29'b0, bootmode_i, fen_eff};
          end
        end
        default: ;
      endcase
      if (!exp_err && req_we_q) begin
        exp_mask = '0;
      end
    end
  end

  // ----------------------------------------
  // Transfer tracking and mirrors
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      start_pipe_q <= '0;
      req_we_q     <= 1'b0;
      req_adr_q    <= '0;
      req_dat_q    <= '0;
      req_sel_q    <= '0;
      fen_q        <= 1'b0;
      boot_addr_q  <= island_map_pkg::BootAddrReset;
      for (int i = 0; i < BankNumWords; i++) begin
        shadow_vld[i] <= '0;
      end
    end else begin
      start_pipe_q <= {start_pipe_q[0], start};
      if (start) begin
        busy_q    <= 1'b1;
        req_we_q  <= wb_we_i;
        req_adr_q <= wb_adr_i;
        req_dat_q <= wb_dat_i;
        req_sel_q <= wb_sel_i;
      end else if (done) begin
        busy_q <= 1'b0;
      end
      if (wb_ack_o && req_we_q && req_adr_q[31:12] == island_map_pkg::BankRegion) begin
        shadow_vld[bank_idx] <= shadow_vld[bank_idx] | req_sel_q;
      end
      if (wb_ack_o && req_we_q && req_adr_q[31:12] == island_map_pkg::CtrlRegion) begin
        if (req_adr_q[11:0] == island_map_pkg::FetchEnOffset && req_sel_q[0]) begin
          fen_q <= req_dat_q[0];
        end
        if (req_adr_q[11:0] == island_map_pkg::BootAddrOffset) begin
          for (int b = 0; b < island_bus_pkg::StrbWidth; b++) begin
            if (req_sel_q[b]) begin
              boot_addr_q[8*b +: 8] <= req_dat_q[8*b +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_ack_o && req_we_q && req_adr_q[31:12] == island_map_pkg::BankRegion) begin
      for (int b = 0; b < island_bus_pkg::StrbWidth; b++) begin
        if (req_sel_q[b]) begin
          shadow[bank_idx][8*b +: 8] <= req_dat_q[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Handshake
  // ----------------------------------------
  a_no_early_reply: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_pipe_q[0] |-> !done)
    else begin
      $error("Reply came one cycle after the start edge instead of two");
      fail_cnt++;
    end

  a_one_reply: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_pipe_q[1] |-> (wb_ack_o ^ wb_err_o))
    else begin
      $error("No single ack or err two cycles after the start edge");
      fail_cnt++;
    end

  a_ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(wb_ack_o && wb_err_o))
    else begin
      $error("Ack and err are high together");
      fail_cnt++;
    end

  a_reply_in_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done |-> (wb_cyc_i && wb_stb_i && start_pipe_q[1]))
    else begin
      $error("Reply seen outside a started transfer");
      fail_cnt++;
    end

  // ----------------------------------------
  // Reply content and outputs
  // ----------------------------------------
  a_err_flag: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done |-> (wb_err_o == exp_err))
    else begin
      $error("ERR wb_err_o adr %h exp %h got %h", req_adr_q, exp_err, wb_err_o);
      fail_cnt++;
    end

  a_rdata: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done |-> (((wb_dat_o ^ exp_data) & exp_mask) == '0))
    else begin
      $error("ERR wb_dat_o adr %h exp %h got %h mask %h", req_adr_q, exp_data, wb_dat_o,
             exp_mask);
      fail_cnt++;
    end

  a_fetch_enable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_q |-> (fetch_enable_o == fen_eff))
    else begin
      $error("ERR fetch_enable_o exp %h got %h", fen_eff, fetch_enable_o);
      fail_cnt++;
    end

  a_boot_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !busy_q |-> (boot_addr_o == boot_addr_q))
    else begin
      $error("ERR boot_addr_o exp %h got %h", boot_addr_q, boot_addr_o);
      fail_cnt++;
    end

endmodule

bind island_top island_assert #(
  .BankNumWords ( BankNumWords )
) u_assert (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .wb_cyc_i       ( wb_cyc_i       ),
  .wb_stb_i       ( wb_stb_i       ),
  .wb_we_i        ( wb_we_i        ),
  .wb_adr_i       ( wb_adr_i       ),
  .wb_dat_i       ( wb_dat_i       ),
  .wb_sel_i       ( wb_sel_i       ),
  .wb_dat_o       ( wb_dat_o       ),
  .wb_ack_o       ( wb_ack_o       ),
  .wb_err_o       ( wb_err_o       ),
  .bootmode_i     ( bootmode_i     ),
  .fetch_enable_o ( fetch_enable_o ),
  .boot_addr_o    ( boot_addr_o    )
);

/* bench/tb_island.sv */
`timescale 1ns/1ps

module tb_island;

  // About 140 transfers of three cycles plus a wide margin
  localparam int unsigned CycleLimit = 2000;
  localparam int unsigned ReplyLimit = 8;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      wb_cyc_i;
  logic                      wb_stb_i;
  logic                      wb_we_i;
  island_bus_pkg::addr_t     wb_adr_i;
  island_bus_pkg::data_t     wb_dat_i;
  island_bus_pkg::strb_t     wb_sel_i;
  island_bus_pkg::data_t     wb_dat_o;
  logic                      wb_ack_o;
  logic                      wb_err_o;
  island_map_pkg::bootmode_e bootmode_i;
  logic                      fetch_enable_o;
  island_bus_pkg::addr_t     boot_addr_o;

  logic [31:0]               rng_q;
  int unsigned               cycles = 0;
  int unsigned               timeouts = 0;
  int unsigned               failures;

  island_top uut (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .wb_cyc_i       ( wb_cyc_i       ),
    .wb_stb_i       ( wb_stb_i       ),
    .wb_we_i        ( wb_we_i        ),
    .wb_adr_i       ( wb_adr_i       ),
    .wb_dat_i       ( wb_dat_i       ),
    .wb_sel_i       ( wb_sel_i       ),
    .wb_dat_o       ( wb_dat_o       ),
    .wb_ack_o       ( wb_ack_o       ),
    .wb_err_o       ( wb_err_o       ),
    .bootmode_i     ( bootmode_i     ),
    .fetch_enable_o ( fetch_enable_o ),
    .boot_addr_o    ( boot_addr_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Run stopped after %0d cycles without reaching the end", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_q = rng_q ^ (rng_q << 13);
    rng_q = rng_q ^ (rng_q >> 17);
    rng_q = rng_q ^ (rng_q << 5);
    return rng_q;
  endfunction

  // ----------------------------------------
  // One Wishbone classic transfer
  // ----------------------------------------
  task automatic bus_xfer(input logic we, input island_bus_pkg::addr_t adr,
                          input island_bus_pkg::data_t dat, input island_bus_pkg::strb_t sel);
    int unsigned waited;
    waited   = 0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    wb_sel_i = sel;
    @(negedge clk_i);
    while (!(wb_ack_o || wb_err_o) && waited < ReplyLimit) begin
      @(negedge clk_i);
      waited++;
    end
    if (!(wb_ack_o || wb_err_o)) begin
      $display("No ack or err for address %h within %0d cycles", adr, ReplyLimit);
      timeouts++;
    end
    // Hold until the reply edge has passed
    @(negedge clk_i);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    rng_q      = 32'd6;
    rst_ni     = 1'b0;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    wb_sel_i   = '0;
    bootmode_i = island_map_pkg::BootLocal;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // SRAM over 32 words so writes overlap
    repeat (60) begin
      r = next_rand();
      bus_xfer(1'b1, {25'b0, r[4:0], 2'b00}, next_rand(), r[11:8]);
    end
    for (int i = 0; i < 32; i++) begin
      bus_xfer(1'b0, 32'(i) << 2, '0, '1);
    end

    // Boot ROM reads where indices past 63 wrap
    repeat (18) begin
      r = next_rand();
      bus_xfer(1'b0, {20'h00001, r[9:0], 2'b00}, '0, '1);
    end
    bus_xfer(1'b1, 32'h0000_1000, next_rand(), '1);
    bus_xfer(1'b1, 32'h0000_10FC, next_rand(), 4'h3);

    // Control registers
    bus_xfer(1'b0, 32'h0000_2004, '0, '1);
    bus_xfer(1'b1, 32'h0000_2004, next_rand(), '1);
    bus_xfer(1'b0, 32'h0000_2004, '0, '1);
    bus_xfer(1'b1, 32'h0000_2004, next_rand(), 4'b0100);
    bus_xfer(1'b0, 32'h0000_2004, '0, '1);
    bus_xfer(1'b1, 32'h0000_2000, 32'h1, 4'h1);
    bus_xfer(1'b0, 32'h0000_2000, '0, '1);
    bus_xfer(1'b0, 32'h0000_2008, '0, '1);
    bus_xfer(1'b1, 32'h0000_2000, 32'h0, 4'h1);

    // JTAG boot forces fetch enable
    bootmode_i = island_map_pkg::BootJtag;
    @(negedge clk_i);
    bus_xfer(1'b0, 32'h0000_2008, '0, '1);
    bootmode_i = island_map_pkg::BootSerial;
    bus_xfer(1'b0, 32'h0000_2008, '0, '1);
    bootmode_i = island_map_pkg::BootLocal;
    bus_xfer(1'b1, 32'h0000_2008, '1, '1);
    bus_xfer(1'b0, 32'h0000_200C, '0, '1);

    // Unmapped regions
    repeat (10) begin
      r = next_rand();
      if (r[31:12] < 20'h3) begin
        r[31:12] = r[31:12] + 20'h3;
      end
      bus_xfer(r[0], r, next_rand(), r[7:4]);
    end

    repeat (2) @(negedge clk_i);
    failures = uut.u_assert.fail_cnt + timeouts;
    $display("Assertion failures %0d, reply timeouts %0d", uut.u_assert.fail_cnt, timeouts);
    if (failures == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* sim.f */
hdl/island_bus_pkg.sv
hdl/island_map_pkg.sv
hdl/periph_bus_if.sv
hdl/wb_frontend.sv
hdl/sram_bank.sv
hdl/boot_rom.sv
hdl/soc_ctrl_regs.sv
hdl/island_top.sv
bench/island_assert.sv
bench/tb_island.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_island \
  -Mdir obj_dir -o sim_island

# Keep running past assertion errors so the closing summary is printed
./obj_dir/sim_island +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q 'Test failures found' sim.log; then
  exit 1
fi
grep -q 'All tests passed!' sim.log
